/* decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Datapath widths
`define XLEN           32
`define NW_BITS        2
`define NUM_THREADS    4
`define UUID_BITS      8
`define NR_BITS        5
`define CSR_ADDR_BITS  12

// RV32IM major opcodes
`define OPC_I      7'b0010011
`define OPC_R      7'b0110011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_B      7'b1100011
`define OPC_L      7'b0000011
`define OPC_S      7'b0100011
`define OPC_FENCE  7'b0001111
`define OPC_SYS    7'b1110011

// Instruction field positions (low bit)
`define OPC_LSB    0
`define RD_LSB     7
`define F3_LSB     12
`define RS1_LSB    15
`define RS2_LSB    20
`define F7_LSB     25
`define F12_LSB    20

// Field widths
`define OPC_BITS   7
`define F3_BITS    3
`define F7_BITS    7
`define F12_BITS   12

`endif

/* decode_pkg.sv */
package decode_pkg;

`include "decode_consts.svh"

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_type_e;

    typedef logic [3:0] op_t;
    typedef logic [2:0] op_mod_t;

    // ALU ops
    localparam op_t ALU_ADD   = 4'd0;
    localparam op_t ALU_SUB   = 4'd1;
    localparam op_t ALU_SLL   = 4'd2;
    localparam op_t ALU_SLT   = 4'd3;
    localparam op_t ALU_SLTU  = 4'd4;
    localparam op_t ALU_XOR   = 4'd5;
    localparam op_t ALU_SRL   = 4'd6;
    localparam op_t ALU_SRA   = 4'd7;
    localparam op_t ALU_OR    = 4'd8;
    localparam op_t ALU_AND   = 4'd9;
    localparam op_t ALU_LUI   = 4'd10;
    localparam op_t ALU_AUIPC = 4'd11;

    // Branch and system ops, issued with MOD_BR
    localparam op_t BR_EQ     = 4'd0;
    localparam op_t BR_NE     = 4'd1;
    localparam op_t BR_LT     = 4'd2;
    localparam op_t BR_GE     = 4'd3;
    localparam op_t BR_LTU    = 4'd4;
    localparam op_t BR_GEU    = 4'd5;
    localparam op_t BR_JAL    = 4'd6;
    localparam op_t BR_JALR   = 4'd7;
    localparam op_t BR_ECALL  = 4'd8;
    localparam op_t BR_EBREAK = 4'd9;
    localparam op_t BR_URET   = 4'd10;
    localparam op_t BR_SRET   = 4'd11;
    localparam op_t BR_MRET   = 4'd12;

    // Multiply/divide, func3 order
    localparam op_t M_MUL     = 4'd0;
    localparam op_t M_MULH    = 4'd1;
    localparam op_t M_MULHSU  = 4'd2;
    localparam op_t M_MULHU   = 4'd3;
    localparam op_t M_DIV     = 4'd4;
    localparam op_t M_DIVU    = 4'd5;
    localparam op_t M_REM     = 4'd6;
    localparam op_t M_REMU    = 4'd7;

    localparam op_t LSU_FENCE = 4'hF; // Store bit with func3 7, not a real store

    localparam op_t SFU_CSRRW = 4'd1;
    localparam op_t SFU_CSRRS = 4'd2;
    localparam op_t SFU_CSRRC = 4'd3;

    localparam op_mod_t MOD_BR  = 3'b001;
    localparam op_mod_t MOD_MUL = 3'b010;

    typedef enum logic [2:0] {
        IMM_I, IMM_SH, IMM_S, IMM_B, IMM_U, IMM_J, IMM_CSR, IMM_FOUR
    } imm_fmt_e;

    typedef struct packed {
        logic [`UUID_BITS-1:0]   uuid;
        logic [`NW_BITS-1:0]     wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        pc;
        logic [31:0]             instr;
    } fetch_data_t;

    typedef struct packed {
        logic [`UUID_BITS-1:0]   uuid;
        logic [`NW_BITS-1:0]     wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        pc;
        ex_type_e                ex_type;
        op_t                     op_type;
        op_mod_t                 op_mod;
        logic                    use_pc;
        logic                    use_imm;
        logic                    wb;
        logic [`NR_BITS-1:0]     rd;
        logic [`NR_BITS-1:0]     rs1;
        logic [`NR_BITS-1:0]     rs2;
        logic [`XLEN-1:0]        imm;
    } decode_data_t;

    typedef struct packed {
        logic                valid;
        logic [`NW_BITS-1:0] wid;
        logic                is_wstall;
    } sched_notice_t;

endpackage

/* op_tables.sv */
`timescale 1ns/100ps

module op_tables (
    input  logic [2:0]      func3,
    input  logic [6:0]      func7,
    input  logic [11:0]     func12,
    input  logic            is_reg_op,
    output decode_pkg::op_t alu_op,
    output decode_pkg::op_t br_op,
    output decode_pkg::op_t mul_op,
    output decode_pkg::op_t sys_op
);

    always_comb begin
        case (func3)
            3'h0: alu_op = (is_reg_op && func7[5]) ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
            3'h1: alu_op = decode_pkg::ALU_SLL;
            3'h2: alu_op = decode_pkg::ALU_SLT;
            3'h3: alu_op = decode_pkg::ALU_SLTU;
            3'h4: alu_op = decode_pkg::ALU_XOR;
            3'h5: alu_op = func7[5] ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL; // SRAI too
            3'h6: alu_op = decode_pkg::ALU_OR;
            default: alu_op = decode_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        case (func3)
            3'h1: br_op = decode_pkg::BR_NE;
            3'h4: br_op = decode_pkg::BR_LT;
            3'h5: br_op = decode_pkg::BR_GE;
            3'h6: br_op = decode_pkg::BR_LTU;
            3'h7: br_op = decode_pkg::BR_GEU;
            default: br_op = decode_pkg::BR_EQ; // 2 and 3 are reserved
        endcase
    end

    always_comb begin
        case (func3)
            3'h0: mul_op = decode_pkg::M_MUL;
            3'h1: mul_op = decode_pkg::M_MULH;
            3'h2: mul_op = decode_pkg::M_MULHSU;
            3'h3: mul_op = decode_pkg::M_MULHU;
            3'h4: mul_op = decode_pkg::M_DIV;
            3'h5: mul_op = decode_pkg::M_DIVU;
            3'h6: mul_op = decode_pkg::M_REM;
            default: mul_op = decode_pkg::M_REMU;
        endcase
    end

    always_comb begin
        case (func12)
            12'h001: sys_op = decode_pkg::BR_EBREAK;
            12'h002: sys_op = decode_pkg::BR_URET;
            12'h102: sys_op = decode_pkg::BR_SRET;
            12'h302: sys_op = decode_pkg::BR_MRET;
            default: sys_op = decode_pkg::BR_ECALL;
        endcase
    end

endmodule

/* imm_gen.sv */
`timescale 1ns/100ps

`include "decode_consts.svh"

module imm_gen (
    input  logic [31:0]          instr,
    input  decode_pkg::imm_fmt_e fmt,
    output logic [`XLEN-1:0]     imm
);

    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [12:0] b_imm;
    logic [31:0] u_imm;
    logic [20:0] j_imm;

    assign i_imm = instr[31:20];
    assign s_imm = {instr[31:25], instr[11:7]};
    assign b_imm = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};
    assign j_imm = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (fmt)
            decode_pkg::IMM_SH:   imm = `XLEN'(instr[24:20]); // Shift amount, unsigned
            decode_pkg::IMM_S:    imm = `XLEN'($signed(s_imm));
            decode_pkg::IMM_B:    imm = `XLEN'($signed(b_imm));
            decode_pkg::IMM_U:    imm = `XLEN'($signed(u_imm));
            decode_pkg::IMM_J:    imm = `XLEN'($signed(j_imm));
            decode_pkg::IMM_CSR: begin
                // uimm above the CSR address
                imm = `XLEN'({instr[`RS1_LSB +: `NR_BITS], instr[31 -: `CSR_ADDR_BITS]});
            end
            decode_pkg::IMM_FOUR: imm = `XLEN'(4);
            default:              imm = `XLEN'($signed(i_imm));
        endcase
    end

endmodule

/* decode_ctrl.sv */
`timescale 1ns/100ps

`include "decode_consts.svh"

module decode_ctrl (
    input  logic                       fetch_valid,
    input  logic                       fetch_ready,
    input  decode_pkg::fetch_data_t    fetch_data,
    output decode_pkg::decode_data_t   decoded,
    output decode_pkg::sched_notice_t  sched
);

    logic [31:0]            instr;
    logic [`OPC_BITS-1:0]   opcode;
    logic [`F3_BITS-1:0]    func3;
    logic [`F7_BITS-1:0]    func7;
    logic [`F12_BITS-1:0]   func12;
    logic [`NR_BITS-1:0]    rd;
    logic [`NR_BITS-1:0]    rs1;
    logic [`NR_BITS-1:0]    rs2;

    decode_pkg::op_t        alu_op;
    decode_pkg::op_t        br_op;
    decode_pkg::op_t        mul_op;
    decode_pkg::op_t        sys_op;
    decode_pkg::imm_fmt_e   fmt;
    logic [`XLEN-1:0]       imm;

    decode_pkg::ex_type_e   ex_type;
    decode_pkg::op_t        op_type;
    decode_pkg::op_mod_t    op_mod;
    logic                   use_pc;
    logic                   use_imm;
    logic                   use_rd;
    logic                   has_imm;
    logic                   is_wstall;
    logic [`NR_BITS-1:0]    rd_idx;
    logic [`NR_BITS-1:0]    rs1_idx;
    logic [`NR_BITS-1:0]    rs2_idx;

    assign instr  = fetch_data.instr;
    assign opcode = instr[`OPC_LSB +: `OPC_BITS];
    assign func3  = instr[`F3_LSB +: `F3_BITS];
    assign func7  = instr[`F7_LSB +: `F7_BITS];
    assign func12 = instr[`F12_LSB +: `F12_BITS];
    assign rd     = instr[`RD_LSB +: `NR_BITS];
    assign rs1    = instr[`RS1_LSB +: `NR_BITS];
    assign rs2    = instr[`RS2_LSB +: `NR_BITS];

    op_tables u_op_tables (
        .func3     (func3),
        .func7     (func7),
        .func12    (func12),
        .is_reg_op (opcode == `OPC_R),
        .alu_op    (alu_op),
        .br_op     (br_op),
        .mul_op    (mul_op),
        .sys_op    (sys_op)
    );

    imm_gen u_imm_gen (
        .instr (instr),
        .fmt   (fmt),
        .imm   (imm)
    );

    always_comb begin
        ex_type   = decode_pkg::EX_ALU;
        op_type   = '0;
        op_mod    = '0;
        use_pc    = 1'b0;
        use_imm   = 1'b0;
        use_rd    = 1'b0;
        has_imm   = 1'b0;
        is_wstall = 1'b0;
        fmt       = decode_pkg::IMM_I;
        rd_idx    = '0;
        rs1_idx   = '0;
        rs2_idx   = '0;
        case (opcode)
            `OPC_I: begin
                op_type = alu_op;
                use_imm = 1'b1;
                use_rd  = 1'b1;
                has_imm = 1'b1;
                fmt     = (func3[1:0] == 2'b01) ? decode_pkg::IMM_SH : decode_pkg::IMM_I;
                rd_idx  = rd;
                rs1_idx = rs1;
            end
            `OPC_R: begin
                op_type = func7[0] ? mul_op : alu_op;
                op_mod  = func7[0] ? decode_pkg::MOD_MUL : '0;
                use_rd  = 1'b1;
                rd_idx  = rd;
                rs1_idx = rs1;
                rs2_idx = rs2;
            end
            `OPC_LUI, `OPC_AUIPC: begin
                op_type = opcode[5] ? decode_pkg::ALU_LUI : decode_pkg::ALU_AUIPC;
                use_pc  = ~opcode[5];
                use_imm = 1'b1;
                use_rd  = 1'b1;
                has_imm = 1'b1;
                fmt     = decode_pkg::IMM_U;
                rd_idx  = rd;
            end
            `OPC_JAL, `OPC_JALR: begin
                op_type   = opcode[3] ? decode_pkg::BR_JAL : decode_pkg::BR_JALR;
                op_mod    = decode_pkg::MOD_BR;
                use_pc    = opcode[3]; // JALR is rs1 relative
                use_imm   = 1'b1;
                use_rd    = 1'b1;
                has_imm   = 1'b1;
                is_wstall = 1'b1;
                fmt       = opcode[3] ? decode_pkg::IMM_J : decode_pkg::IMM_I;
                rd_idx    = rd;
                rs1_idx   = opcode[3] ? '0 : rs1;
            end
            `OPC_B: begin
                op_type   = br_op;
                op_mod    = decode_pkg::MOD_BR;
                use_pc    = 1'b1;
                use_imm   = 1'b1;
                has_imm   = 1'b1;
                is_wstall = 1'b1;
                fmt       = decode_pkg::IMM_B;
                rs1_idx   = rs1;
                rs2_idx   = rs2;
            end
            `OPC_L, `OPC_S: begin
                ex_type = decode_pkg::EX_LSU;
                op_type = {opcode[5], func3}; // Store flag on top
                use_imm = 1'b1;
                use_rd  = ~opcode[5];
                has_imm = 1'b1;
                fmt     = opcode[5] ? decode_pkg::IMM_S : decode_pkg::IMM_I;
                rd_idx  = opcode[5] ? '0 : rd;
                rs1_idx = rs1;
                rs2_idx = opcode[5] ? rs2 : '0;
            end
            `OPC_FENCE: begin
                ex_type = decode_pkg::EX_LSU;
                op_type = decode_pkg::LSU_FENCE;
            end
            `OPC_SYS: begin
                use_rd    = 1'b1;
                has_imm   = 1'b1;
                is_wstall = 1'b1;
                rd_idx    = rd;
                if (func3[1:0] != 2'b00) begin
                    ex_type = decode_pkg::EX_SFU;
                    op_type = {2'b00, func3[1:0]};
                    use_imm = func3[2];
                    fmt     = decode_pkg::IMM_CSR;
                    rs1_idx = func3[2] ? '0 : rs1;
                end else begin
                    op_type = sys_op;
                    op_mod  = decode_pkg::MOD_BR;
                    use_pc  = 1'b1;
                    use_imm = 1'b1;
                    fmt     = decode_pkg::IMM_FOUR; // Return address
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        decoded.uuid    = fetch_data.uuid;
        decoded.wid     = fetch_data.wid;
        decoded.tmask   = fetch_data.tmask;
        decoded.pc      = fetch_data.pc;
        decoded.ex_type = ex_type;
        decoded.op_type = op_type;
        decoded.op_mod  = op_mod;
        decoded.use_pc  = use_pc;
        decoded.use_imm = use_imm;
        decoded.wb      = use_rd && (rd_idx != '0); // x0 is never written
        decoded.rd      = rd_idx;
        decoded.rs1     = rs1_idx;
        decoded.rs2     = rs2_idx;
        decoded.imm     = has_imm ? imm : '0;
    end

    assign sched.valid     = fetch_valid && fetch_ready;
    assign sched.wid       = fetch_data.wid;
    assign sched.is_wstall = is_wstall;

endmodule

/* decode_buffer.sv */
`timescale 1ns/100ps

module decode_buffer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  decode_pkg::decode_data_t in_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output decode_pkg::decode_data_t out_data
);

    logic                     main_valid;
    logic                     spill_valid;
    decode_pkg::decode_data_t main_data;
    decode_pkg::decode_data_t spill_data;
    logic                     in_fire;
    logic                     main_stalled;

    assign in_ready     = ~spill_valid; // Straight from a flop
    assign in_fire      = in_valid && in_ready;
    assign main_stalled = main_valid && !out_ready;
    assign out_valid    = main_valid;
    assign out_data     = main_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_valid  <= 1'b0;
            spill_valid <= 1'b0;
        end else if (spill_valid) begin
            if (out_ready)
                spill_valid <= 1'b0; // Spill moves up
        end else if (in_fire) begin
            main_valid  <= 1'b1;
            spill_valid <= main_stalled;
        end else if (out_ready) begin
            main_valid  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (spill_valid) begin
            if (out_ready)
                main_data <= spill_data;
        end else if (in_fire) begin
            if (main_stalled)
                spill_data <= in_data;
            else
                main_data <= in_data;
        end
    end

    // Issue side must see a held entry until it is taken
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

    // A full buffer keeps its spill entry until issue takes one
    assert property (@(posedge clk) disable iff (!rst_n)
        main_valid && spill_valid && !out_ready |=>
            main_valid && spill_valid && $stable(spill_data));

endmodule

/* decode_top.sv */
`timescale 1ns/100ps

module decode_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      fetch_valid,
    output logic                      fetch_ready,
    input  decode_pkg::fetch_data_t   fetch_data,
    output logic                      issue_valid,
    input  logic                      issue_ready,
    output decode_pkg::decode_data_t  issue_data,
    output decode_pkg::sched_notice_t sched
);

    decode_pkg::decode_data_t decoded;

    decode_ctrl u_decode_ctrl (
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .decoded     (decoded),
        .sched       (sched)
    );

    decode_buffer u_decode_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (decoded),
        .out_valid (issue_valid),
        .out_ready (issue_ready),
        .out_data  (issue_data)
    );

endmodule

/* tb_decode.sv */
`timescale 1ns/100ps

`include "decode_consts.svh"

module tb_decode;

    localparam int STREAM_LEN = 40;
    // 21 directed ops under 20 cycles each plus 40 streamed under 30 each
    localparam int TIMEOUT_CYCLES = 2000;

    logic                      clk;
    logic                      rst_n;
    logic                      fetch_valid;
    logic                      fetch_ready;
    decode_pkg::fetch_data_t   fetch_data;
    logic                      issue_valid;
    logic                      issue_ready;
    decode_pkg::decode_data_t  issue_data;
    decode_pkg::sched_notice_t sched;

    int          errors;
    int          checks;
    int          cycles;
    int          notice_count;
    logic [31:0] rng_state;
    logic [7:0]  uuid_next;

    // Every directed case is reused as the stream's pool
    logic [31:0]              case_instr[$];
    decode_pkg::decode_data_t case_exp[$];
    logic                     case_wstall[$];

    decode_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_data  (issue_data),
        .sched       (sched)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped moving instructions", cycles);
            $display("sim failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (sched.valid === 1'b1)
            notice_count = notice_count + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Standard RV32 encodings
    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [6:0] opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [6:0] opc);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
    endfunction

    function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
    endfunction

    // flags is {use_pc, use_imm, wb}
    function automatic decode_pkg::decode_data_t expect_dec(
        input decode_pkg::ex_type_e ex, input decode_pkg::op_t op,
        input decode_pkg::op_mod_t md, input logic [2:0] flags,
        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
        input logic [31:0] imm);
        decode_pkg::decode_data_t d;
        d         = '0;
        d.ex_type = ex;
        d.op_type = op;
        d.op_mod  = md;
        d.use_pc  = flags[2];
        d.use_imm = flags[1];
        d.wb      = flags[0];
        d.rd      = rd;
        d.rs1     = rs1;
        d.rs2     = rs2;
        d.imm     = imm;
        return d;
    endfunction

    task automatic drive_fetch(input decode_pkg::decode_data_t e, input logic [31:0] instr);
        fetch_valid      = 1'b1;
        fetch_data.uuid  = e.uuid;
        fetch_data.wid   = e.wid;
        fetch_data.tmask = e.tmask;
        fetch_data.pc    = e.pc;
        fetch_data.instr = instr;
    endtask

    task automatic check_notice(input string name, input logic [`NW_BITS-1:0] wid,
                                input logic wstall);
        checks++;
        if (sched.valid !== 1'b1) begin
            errors++;
            $display("Error %s sched.valid: expected 1, actual %b", name, sched.valid);
        end
        if (sched.wid !== wid) begin
            errors++;
            $display("Error %s sched.wid: expected %0d, actual %0d", name, wid, sched.wid);
        end
        if (sched.is_wstall !== wstall) begin
            errors++;
            $display("Error %s is_wstall: expected %b, actual %b", name, wstall,
                     sched.is_wstall);
        end
    endtask

    task automatic compare_entry(input string name, input decode_pkg::decode_data_t exp);
        checks++;
        if (issue_data !== exp) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, issue_data);
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        checks++;
        if (fetch_ready !== 1'b1) begin
            errors++;
            $display("Error reset fetch_ready: expected 1, actual %b", fetch_ready);
        end
        if (issue_valid !== 1'b0 || sched.valid !== 1'b0) begin
            errors++;
            $display("Error reset valids: expected 00, actual %b%b", issue_valid, sched.valid);
        end
        @(posedge clk);
        #1;
    endtask

    // One instruction through an empty stage
    task automatic run_one(input string name, input logic [31:0] instr,
                           input decode_pkg::decode_data_t exp_in, input logic exp_wstall);
        decode_pkg::decode_data_t exp;
        int waits;
        exp       = exp_in;
        exp.uuid  = uuid_next;
        exp.wid   = uuid_next[1:0];
        exp.tmask = ~uuid_next[3:0];
        exp.pc    = 32'h0000_2000 + {22'b0, uuid_next, 2'b00};
        case_instr.push_back(instr);
        case_exp.push_back(exp_in);
        case_wstall.push_back(exp_wstall);
        issue_ready = 1'b1;
        drive_fetch(exp, instr);
        @(negedge clk);
        while (!fetch_ready)
            @(negedge clk);
        check_notice(name, exp.wid, exp_wstall);
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;
        waits = 0;
        @(negedge clk);
        while (!issue_valid) begin
            @(negedge clk);
            waits++;
        end
        if (waits != 0) begin
            errors++;
            $display("%s reached issue %0d cycles later than one cycle", name, waits);
        end
        compare_entry(name, exp);
        @(posedge clk);
        #1;
        uuid_next = uuid_next + 8'd1;
    endtask

    task automatic alu_tests();
        run_one("add", encode_r(7'h00, 5'd2, 5'd1, 3'h0, 5'd3, `OPC_R),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::ALU_ADD, 3'b000, 3'b001,
                           5'd3, 5'd1, 5'd2, 32'h0), 1'b0);
        run_one("sub", encode_r(7'h20, 5'd6, 5'd5, 3'h0, 5'd4, `OPC_R),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::ALU_SUB, 3'b000, 3'b001,
                           5'd4, 5'd5, 5'd6, 32'h0), 1'b0);
        run_one("srl", encode_r(7'h00, 5'd9, 5'd8, 3'h5, 5'd7, `OPC_R),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::ALU_SRL, 3'b000, 3'b001,
                           5'd7, 5'd8, 5'd9, 32'h0), 1'b0);
        run_one("sra", encode_r(7'h20, 5'd9, 5'd8, 3'h5, 5'd7, `OPC_R),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::ALU_SRA, 3'b000, 3'b001,
                           5'd7, 5'd8, 5'd9, 32'h0), 1'b0);
        run_one("srai", encode_i(12'h411, 5'd11, 3'h5, 5'd10, `OPC_I),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::ALU_SRA, 3'b000, 3'b011,
                           5'd10, 5'd11, 5'd0, 32'd17), 1'b0);
        // Bit 30 set in the immediate still decodes as an add
        run_one("addi", encode_i(12'hFFB, 5'd13, 3'h0, 5'd12, `OPC_I),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::ALU_ADD, 3'b000, 3'b011,
                           5'd12, 5'd13, 5'd0, 32'hFFFF_FFFB), 1'b0);
    endtask

    task automatic upper_jump_tests();
        run_one("lui", encode_u(20'hABCDE, 5'd1, `OPC_LUI),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::ALU_LUI, 3'b000, 3'b011,
                           5'd1, 5'd0, 5'd0, 32'hABCD_E000), 1'b0);
        run_one("auipc", encode_u(20'h80001, 5'd2, `OPC_AUIPC),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::ALU_AUIPC, 3'b000, 3'b111,
                           5'd2, 5'd0, 5'd0, 32'h8000_1000), 1'b0);
        run_one("jal", encode_j(21'h1F_FFF0, 5'd1, `OPC_JAL),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::BR_JAL, 3'b001, 3'b111,
                           5'd1, 5'd0, 5'd0, 32'hFFFF_FFF0), 1'b1);
        run_one("jalr", encode_i(12'h008, 5'd5, 3'h0, 5'd0, `OPC_JALR),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::BR_JALR, 3'b001, 3'b010,
                           5'd0, 5'd5, 5'd0, 32'h8), 1'b1);
        run_one("bne", encode_b(13'h1F00, 5'd4, 5'd3, 3'h1, `OPC_B),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::BR_NE, 3'b001, 3'b110,
                           5'd0, 5'd3, 5'd4, 32'hFFFF_FF00), 1'b1);
    endtask

    task automatic mem_mul_tests();
        run_one("lw", encode_i(12'hFFC, 5'd7, 3'h2, 5'd6, `OPC_L),
                expect_dec(decode_pkg::EX_LSU, 4'b0010, 3'b000, 3'b011,
                           5'd6, 5'd7, 5'd0, 32'hFFFF_FFFC), 1'b0);
        run_one("sw", encode_s(12'h8A5, 5'd8, 5'd9, 3'h2, `OPC_S),
                expect_dec(decode_pkg::EX_LSU, 4'b1010, 3'b000, 3'b010,
                           5'd0, 5'd9, 5'd8, 32'hFFFF_F8A5), 1'b0);
        run_one("fence", 32'h0FF0_000F,
                expect_dec(decode_pkg::EX_LSU, decode_pkg::LSU_FENCE, 3'b000, 3'b000,
                           5'd0, 5'd0, 5'd0, 32'h0), 1'b0);
        run_one("mul", encode_r(7'h01, 5'd3, 5'd2, 3'h0, 5'd1, `OPC_R),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::M_MUL, 3'b010, 3'b001,
                           5'd1, 5'd2, 5'd3, 32'h0), 1'b0);
        run_one("divu", encode_r(7'h01, 5'd6, 5'd5, 3'h5, 5'd4, `OPC_R),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::M_DIVU, 3'b010, 3'b001,
                           5'd4, 5'd5, 5'd6, 32'h0), 1'b0);
    endtask

    task automatic system_tests();
        run_one("csrrw", encode_i(12'h300, 5'd6, 3'h1, 5'd5, `OPC_SYS),
                expect_dec(decode_pkg::EX_SFU, decode_pkg::SFU_CSRRW, 3'b000, 3'b001,
                           5'd5, 5'd6, 5'd0, 32'h0000_6300), 1'b1);
        // uimm 21 lands in bits 16:12 and rd is x0
        run_one("csrrsi", encode_i(12'h7C0, 5'd21, 3'h6, 5'd0, `OPC_SYS),
                expect_dec(decode_pkg::EX_SFU, decode_pkg::SFU_CSRRS, 3'b000, 3'b010,
                           5'd0, 5'd0, 5'd0, 32'h0001_57C0), 1'b1);
        run_one("ecall", encode_i(12'h000, 5'd0, 3'h0, 5'd0, `OPC_SYS),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::BR_ECALL, 3'b001, 3'b110,
                           5'd0, 5'd0, 5'd0, 32'd4), 1'b1);
        run_one("mret", encode_i(12'h302, 5'd0, 3'h0, 5'd0, `OPC_SYS),
                expect_dec(decode_pkg::EX_ALU, decode_pkg::BR_MRET, 3'b001, 3'b110,
                           5'd0, 5'd0, 5'd0, 32'd4), 1'b1);
        run_one("unknown", 32'hFFFF_FFFF,
                expect_dec(decode_pkg::EX_ALU, 4'd0, 3'b000, 3'b000,
                           5'd0, 5'd0, 5'd0, 32'h0), 1'b0);
    endtask

    task automatic stream_test();
        int idx[STREAM_LEN];
        int received;
        decode_pkg::decode_data_t exp_q[$];
        for (int i = 0; i < STREAM_LEN; i++) begin
            rng_state = xorshift(rng_state);
            idx[i] = int'(rng_state % 32'(case_instr.size()));
        end
        received = 0;
        notice_count = 0;
        fork
            begin : producer
                for (int i = 0; i < STREAM_LEN; i++) begin
                    decode_pkg::decode_data_t e;
                    e       = case_exp[idx[i]];
                    e.uuid  = 8'h80 + 8'(i);
                    e.wid   = 2'(i);
                    e.tmask = 4'(i * 3);
                    e.pc    = 32'h0000_4000 + 32'(i * 4);
                    drive_fetch(e, case_instr[idx[i]]);
                    @(negedge clk);
                    while (!fetch_ready)
                        @(negedge clk);
                    check_notice("stream", e.wid, case_wstall[idx[i]]);
                    exp_q.push_back(e);
                    @(posedge clk);
                    #1;
                end
                fetch_valid = 1'b0;
            end
            begin : consumer
                while (received < STREAM_LEN) begin
                    rng_state = xorshift(rng_state);
                    issue_ready = rng_state[0];
                    @(negedge clk);
                    if (issue_valid && issue_ready) begin
                        if (exp_q.size() == 0) begin
                            errors++;
                            $display("Stream entry reached issue with nothing sent for it");
                        end else begin
                            compare_entry("stream", exp_q.pop_front());
                        end
                        received++;
                    end
                    @(posedge clk);
                    #1;
                end
                issue_ready = 1'b1;
            end
        join
        checks++;
        if (notice_count != STREAM_LEN) begin
            errors++;
            $display("Error stream notices: expected %0d, actual %0d", STREAM_LEN, notice_count);
        end
        @(negedge clk);
        if (issue_valid !== 1'b0 || exp_q.size() != 0) begin
            errors++;
            $display("Stream left %0d entries unmatched or an extra entry on issue",
                     exp_q.size());
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        fetch_valid  = 1'b0;
        fetch_data   = '0;
        issue_ready  = 1'b0;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        notice_count = 0;
        rng_state    = 32'd67035;
        uuid_next    = 8'd1;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_reset_state();
        alu_tests();
        upper_jump_tests();
        mem_mul_tests();
        system_tests();
        stream_test();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+.
decode_pkg.sv
op_tables.sv
imm_gen.sv
decode_ctrl.sv
decode_buffer.sv
decode_top.sv
tb_decode.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tb_decode -o sim_decode \
    && ./obj_dir/sim_decode | tee sim.log
grep -qsx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
